// File: hdl/ntt_consts.svh
/*
 * Constants of the 2x2 NTT butterfly block.
 * Modulus, coefficient width and pipeline latencies.
 */

`ifndef NTT_CONSTS_SVH
`define NTT_CONSTS_SVH

// Prime modulus q = 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417

// Coefficient width in bits
`define NTT_WIDTH 23

// Product register, Barrett estimate, correction
`define NTT_MULT_LATENCY 3

// Multiplier plus the final add/subtract register
`define NTT_BF_LATENCY 4

// Two butterfly layers back to back
`define NTT_2X2_LATENCY (2 * `NTT_BF_LATENCY)

`endif

// File: hdl/ntt_pkg.sv
/*
 * Types of the 2x2 NTT butterfly block.
 * Mode encoding, coefficient type, input groups and result groups.
 */

`default_nettype none

`include "ntt_consts.svh"

package ntt_pkg;

    // Operating mode, shared by all four butterfly units
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    typedef logic [`NTT_WIDTH-1:0] coeff_t;

    // One 2x2 group for ct and gs: layer-1 operands plus layer-2 twiddles
    typedef struct packed {
        coeff_t u00;
        coeff_t v00;
        coeff_t w00;
        coeff_t u01;
        coeff_t v01;
        coeff_t w01;
        coeff_t w10;
        coeff_t w11;
    } bf_uvw_t;

    // Four independent lanes for the pointwise modes
    typedef struct packed {
        coeff_t u0;
        coeff_t u1;
        coeff_t u2;
        coeff_t u3;
        coeff_t v0;
        coeff_t v1;
        coeff_t v2;
        coeff_t v3;
        coeff_t w0;
        coeff_t w1;
        coeff_t w2;
        coeff_t w3;
    } pw_uvw_t;

    // Second-layer results
    typedef struct packed {
        coeff_t u20;
        coeff_t v20;
        coeff_t u21;
        coeff_t v21;
    } bf_uv_t;

    typedef struct packed {
        coeff_t uv0;
        coeff_t uv1;
        coeff_t uv2;
        coeff_t uv3;
    } pw_res_t;

endpackage

`default_nettype wire

// File: hdl/ntt_mod_mult.sv
/*
 * Pipelined modular multiplier, result below q.
 * Product register, Barrett quotient estimate, subtract and one correction.
 */

`default_nettype none

`include "ntt_consts.svh"

module ntt_mod_mult (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);
    import ntt_pkg::*;

    localparam int PROD_W = 2 * `NTT_WIDTH;
    localparam int MU_W   = `NTT_WIDTH + 1;
    // Remainder before correction is below 2q, which fits in 24 bits
    localparam int R_W    = `NTT_WIDTH + 1;

    // floor(2^46 / q)
    localparam logic [MU_W-1:0] BARRETT_MU = MU_W'((64'd1 << PROD_W) / `NTT_Q);

    logic [PROD_W-1:0]      prod_q;
    logic [PROD_W+MU_W-1:0] est_full;
    coeff_t                 quot_q;
    logic [R_W-1:0]         prod_lo_q;
    logic [R_W-1:0]         rem;
    logic [R_W-1:0]         rem_fix;
    coeff_t                 p_q;

    // Full-precision estimate, at most one below the true quotient
    assign est_full = prod_q * BARRETT_MU;

    // Only the low bits matter once the quotient is known
    assign rem     = prod_lo_q - R_W'(quot_q) * R_W'(`NTT_Q);
    assign rem_fix = (rem >= R_W'(`NTT_Q)) ? rem - R_W'(`NTT_Q) : rem;

    // ------------------------------------------------------------------------
    // Three register stages
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q    <= '0;
            quot_q    <= '0;
            prod_lo_q <= '0;
            p_q       <= '0;
        end else if (zeroize_i) begin
            prod_q    <= '0;
            quot_q    <= '0;
            prod_lo_q <= '0;
            p_q       <= '0;
        end else begin
            prod_q    <= a_i * b_i;
            quot_q    <= est_full[PROD_W +: `NTT_WIDTH];
            prod_lo_q <= prod_q[R_W-1:0];
            p_q       <= rem_fix[`NTT_WIDTH-1:0];
        end
    end

    assign p_o = p_q;

    // Estimate error of one quotient step is covered by the single correction
    p_below_q_a: assert property (@(posedge clk) disable iff (!reset_n)
        p_o < `NTT_Q)
        else $error("modular product not reduced below q");

endmodule

`default_nettype wire

// File: hdl/ntt_butterfly.sv
/*
 * One butterfly unit for ct, gs, pwm, pwa and pws.
 * Modular multiplier in front, add/subtract register behind it.
 * Every mode takes the same fixed latency.
 */

`default_nettype none

`include "ntt_consts.svh"

module ntt_butterfly (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::mode_t  mode_i,
    input  logic            accumulate_i,
    input  ntt_pkg::coeff_t u_i,
    input  ntt_pkg::coeff_t v_i,
    input  ntt_pkg::coeff_t w_i,
    output ntt_pkg::coeff_t a_o,
    output ntt_pkg::coeff_t b_o
);
    import ntt_pkg::*;

    // Operands wait while the multiplier works
    localparam int OP_DELAY = `NTT_BF_LATENCY - 1;

    typedef struct packed {
        mode_t  mode;
        logic   acc;
        coeff_t u;
        coeff_t v;
        coeff_t w;
    } stage_op_t;

    function automatic coeff_t mod_add(coeff_t x, coeff_t y);
        logic [`NTT_WIDTH:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= (`NTT_WIDTH+1)'(`NTT_Q)) begin
            s = s - (`NTT_WIDTH+1)'(`NTT_Q);
        end
        return s[`NTT_WIDTH-1:0];
    endfunction

    function automatic coeff_t mod_sub(coeff_t x, coeff_t y);
        coeff_t d;
        d = x - y;
        if (x < y) begin
            d = d + `NTT_Q;
        end
        return d;
    endfunction

    stage_op_t               op_in;
    stage_op_t [OP_DELAY-1:0] op_sr;
    stage_op_t               op_d;
    coeff_t                  mul_a;
    coeff_t                  mul_b;
    coeff_t                  prod;
    coeff_t                  sum_x;
    coeff_t                  sum_y;
    coeff_t                  dif_y;
    coeff_t                  sum;
    coeff_t                  dif;
    coeff_t                  a_nxt;
    coeff_t                  b_nxt;
    coeff_t                  a_q;
    coeff_t                  b_q;

    // ------------------------------------------------------------------------
    // Multiplier operands
    // ------------------------------------------------------------------------
    always_comb begin
        case (mode_i)
            ct: begin
                mul_a = w_i;
                mul_b = v_i;
            end
            // gs multiplies the difference, so it is formed here
            gs: begin
                mul_a = mod_sub(u_i, v_i);
                mul_b = w_i;
            end
            pwm: begin
                mul_a = u_i;
                mul_b = v_i;
            end
            default: begin
                mul_a = '0;
                mul_b = '0;
            end
        endcase
    end

    ntt_mod_mult ntt_mod_mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (prod)
    );

    assign op_in = '{mode: mode_i, acc: accumulate_i, u: u_i, v: v_i, w: w_i};
    assign op_d  = op_sr[OP_DELAY-1];

    // Add/subtract operands once the product is out
    always_comb begin
        sum_x = op_d.u;
        sum_y = op_d.v;
        dif_y = op_d.v;
        case (op_d.mode)
            ct: begin
                sum_y = prod;
                dif_y = prod;
            end
            pwm: begin
                sum_x = prod;
                sum_y = op_d.acc ? op_d.w : '0;
            end
            default: ;
        endcase
    end

    assign sum = mod_add(sum_x, sum_y);
    assign dif = mod_sub(op_d.u, dif_y);

    always_comb begin
        a_nxt = '0;
        b_nxt = '0;
        case (op_d.mode)
            ct: begin
                a_nxt = sum;
                b_nxt = dif;
            end
            gs: begin
                a_nxt = sum;
                b_nxt = prod;
            end
            pwm, pwa: a_nxt = sum;
            pws:      a_nxt = dif;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_sr <= '0;
            a_q   <= '0;
            b_q   <= '0;
        end else if (zeroize_i) begin
            op_sr <= '0;
            a_q   <= '0;
            b_q   <= '0;
        end else begin
            op_sr <= {op_sr[OP_DELAY-2:0], op_in};
            a_q   <= a_nxt;
            b_q   <= b_nxt;
        end
    end

    assign a_o = a_q;
    assign b_o = b_q;

endmodule

`default_nettype wire

// File: hdl/ntt_butterfly_2x2.sv
/*
 * Two-layer 2x2 NTT butterfly, top level.
 * Operand selection, four butterfly units, layer-2 twiddle delay,
 * output mapping and ready generation.
 */

`default_nettype none

`include "ntt_consts.svh"

module ntt_butterfly_2x2 (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize_i,
    input  logic             enable_i,
    input  logic             accumulate_i,
    input  ntt_pkg::mode_t   mode_i,
    input  ntt_pkg::bf_uvw_t uvw_i,
    input  ntt_pkg::pw_uvw_t pw_uvw_i,
    output ntt_pkg::bf_uv_t  uv_o,
    output ntt_pkg::pw_res_t pw_uv_o,
    output logic             ready_o
);
    import ntt_pkg::*;

    localparam int BF_LAT  = `NTT_BF_LATENCY;
    localparam int RDY_LEN = `NTT_2X2_LATENCY;
    localparam int NUM_BF  = 4;

    typedef struct packed {
        coeff_t u;
        coeff_t v;
        coeff_t w;
    } unit_op_t;

    typedef struct packed {
        coeff_t w10;
        coeff_t w11;
    } tw_pair_t;

    logic                    pw_mode;
    unit_op_t [NUM_BF-1:0]   bf_op;
    coeff_t   [NUM_BF-1:0]   bf_a;
    coeff_t   [NUM_BF-1:0]   bf_b;
    tw_pair_t                tw_in;
    tw_pair_t [BF_LAT-1:0]   tw_sr;
    tw_pair_t                tw_d;
    logic     [RDY_LEN-1:0]  ready_sr;

    assign pw_mode = mode_i inside {pwm, pwa, pws};

    // ------------------------------------------------------------------------
    // Twiddle delay for layer 2
    // ------------------------------------------------------------------------
    // Layer-2 twiddles must meet the layer-1 results of the same group
    assign tw_in = '{w10: uvw_i.w10, w11: uvw_i.w11};
    assign tw_d  = tw_sr[BF_LAT-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tw_sr <= '0;
        end else if (zeroize_i) begin
            tw_sr <= '0;
        end else begin
            tw_sr <= {tw_sr[BF_LAT-2:0], tw_in};
        end
    end

    // ------------------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------------------
    always_comb begin
        if (pw_mode) begin
            // Four independent lanes, all issued together
            bf_op[0] = '{u: pw_uvw_i.u0, v: pw_uvw_i.v0, w: pw_uvw_i.w0};
            bf_op[1] = '{u: pw_uvw_i.u1, v: pw_uvw_i.v1, w: pw_uvw_i.w1};
            bf_op[2] = '{u: pw_uvw_i.u2, v: pw_uvw_i.v2, w: pw_uvw_i.w2};
            bf_op[3] = '{u: pw_uvw_i.u3, v: pw_uvw_i.v3, w: pw_uvw_i.w3};
        end else begin
            bf_op[0] = '{u: uvw_i.u00, v: uvw_i.v00, w: uvw_i.w00};
            bf_op[1] = '{u: uvw_i.u01, v: uvw_i.v01, w: uvw_i.w01};
            // x0/y0 and x1/y1 cross over into the second layer
            bf_op[2] = '{u: bf_a[0], v: bf_a[1], w: tw_d.w10};
            bf_op[3] = '{u: bf_b[0], v: bf_b[1], w: tw_d.w11};
        end
    end

    // Units 0 and 1 form layer 1, units 2 and 3 layer 2
    for (genvar k = 0; k < NUM_BF; k++) begin : g_bf
        ntt_butterfly ntt_butterfly_i (
            .clk          (clk),
            .reset_n      (reset_n),
            .zeroize_i    (zeroize_i),
            .mode_i       (mode_i),
            .accumulate_i (accumulate_i),
            .u_i          (bf_op[k].u),
            .v_i          (bf_op[k].v),
            .w_i          (bf_op[k].w),
            .a_o          (bf_a[k]),
            .b_o          (bf_b[k])
        );
    end

    // ------------------------------------------------------------------------
    // Ready generation
    // ------------------------------------------------------------------------
    // Bit position is the number of cycles left until ready, so an enable
    // enters at the slot matching the mode latency and always leaves at bit 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= '0;
        end else if (zeroize_i) begin
            ready_sr <= '0;
        end else if (pw_mode) begin
            ready_sr <= {{(RDY_LEN-BF_LAT){1'b0}}, enable_i, ready_sr[BF_LAT-1:1]};
        end else begin
            ready_sr <= {enable_i, ready_sr[RDY_LEN-1:1]};
        end
    end

    assign ready_o = ready_sr[0];

    // Results only show during the ready cycle
    always_comb begin
        uv_o    = '0;
        pw_uv_o = '0;
        if (ready_o) begin
            if (pw_mode) begin
                pw_uv_o = '{uv0: bf_a[0], uv1: bf_a[1], uv2: bf_a[2], uv3: bf_a[3]};
            end else begin
                uv_o = '{u20: bf_a[2], v20: bf_b[2], u21: bf_a[3], v21: bf_b[3]};
            end
        end
    end

    // Units and ready slot both follow mode_i, so it must hold for every group
    mode_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
        (!zeroize_i && (|ready_sr)) |-> $stable(mode_i))
        else $error("mode_i changed while groups were in flight");

endmodule

`default_nettype wire

// File: dv/ntt_ref_model.svh
/*
 * Reference arithmetic for the 2x2 NTT butterfly testbench.
 * Modular add, subtract and multiply, 2x2 ct and gs groups, pointwise lanes.
 */

`ifndef NTT_REF_MODEL_SVH
`define NTT_REF_MODEL_SVH

function automatic coeff_t add_mod(coeff_t x, coeff_t y);
    logic [31:0] s;
    s = 32'(x) + 32'(y);
    return coeff_t'(s % 32'(`NTT_Q));
endfunction

function automatic coeff_t sub_mod(coeff_t x, coeff_t y);
    logic [31:0] d;
    d = 32'(x) + 32'(`NTT_Q) - 32'(y);
    return coeff_t'(d % 32'(`NTT_Q));
endfunction

// Plain remainder, wide enough for the full product
function automatic coeff_t mul_mod(coeff_t x, coeff_t y);
    logic [63:0] p;
    p = 64'(x) * 64'(y);
    return coeff_t'(p % 64'(`NTT_Q));
endfunction

function automatic bf_uv_t ct_group(bf_uvw_t g);
    coeff_t x0, x1, y0, y1, t;
    bf_uv_t r;
    t  = mul_mod(g.w00, g.v00);
    x0 = add_mod(g.u00, t);
    x1 = sub_mod(g.u00, t);
    t  = mul_mod(g.w01, g.v01);
    y0 = add_mod(g.u01, t);
    y1 = sub_mod(g.u01, t);
    t  = mul_mod(g.w10, y0);
    r.u20 = add_mod(x0, t);
    r.v20 = sub_mod(x0, t);
    t  = mul_mod(g.w11, y1);
    r.u21 = add_mod(x1, t);
    r.v21 = sub_mod(x1, t);
    return r;
endfunction

function automatic bf_uv_t gs_group(bf_uvw_t g);
    coeff_t x0, x1, y0, y1;
    bf_uv_t r;
    x0 = add_mod(g.u00, g.v00);
    x1 = mul_mod(sub_mod(g.u00, g.v00), g.w00);
    y0 = add_mod(g.u01, g.v01);
    y1 = mul_mod(sub_mod(g.u01, g.v01), g.w01);
    r.u20 = add_mod(x0, y0);
    r.v20 = mul_mod(sub_mod(x0, y0), g.w10);
    r.u21 = add_mod(x1, y1);
    r.v21 = mul_mod(sub_mod(x1, y1), g.w11);
    return r;
endfunction

function automatic coeff_t pointwise_lane(mode_t m, logic acc, coeff_t u, coeff_t v, coeff_t w);
    case (m)
        pwm:     return acc ? add_mod(mul_mod(u, v), w) : mul_mod(u, v);
        pwa:     return add_mod(u, v);
        pws:     return sub_mod(u, v);
        default: return '0;
    endcase
endfunction

function automatic pw_res_t pw_group(mode_t m, logic acc, pw_uvw_t g);
    pw_res_t r;
    r.uv0 = pointwise_lane(m, acc, g.u0, g.v0, g.w0);
    r.uv1 = pointwise_lane(m, acc, g.u1, g.v1, g.w1);
    r.uv2 = pointwise_lane(m, acc, g.u2, g.v2, g.w2);
    r.uv3 = pointwise_lane(m, acc, g.u3, g.v3, g.w3);
    return r;
endfunction

`endif

// File: dv/tb_ntt_butterfly_2x2.sv
/*
 * Testbench for the 2x2 NTT butterfly block.
 * Clock, reset, random operands, output checking against a queue of
 * expected groups, directed tests and a watchdog.
 */

`default_nettype none

`include "ntt_consts.svh"

module tb_ntt_butterfly_2x2;
    timeunit 1ns;
    timeprecision 1ps;

    import ntt_pkg::*;

    `include "ntt_ref_model.svh"

    localparam int LAT1 = `NTT_BF_LATENCY;
    localparam int LAT2 = `NTT_2X2_LATENCY;
    localparam int ZERO_GROUPS = 4;
    localparam int NUM_GROUPS = 20 + 20 + 4 * 10 + ZERO_GROUPS + 1;
    localparam int WATCHDOG_CYCLES = 16 + NUM_GROUPS * (LAT2 + 4) + 200;

    // One group in flight and the response it must produce
    typedef struct packed {
        logic        pw;
        logic [31:0] due;
        bf_uv_t      uv;
        pw_res_t     pw_uv;
    } expect_t;

    logic     clk;
    logic     reset_n;
    logic     zeroize;
    logic     enable;
    logic     accumulate;
    mode_t    mode;
    bf_uvw_t  uvw;
    pw_uvw_t  pw_uvw;
    bf_uv_t   uv;
    pw_res_t  pw_uv;
    logic     ready;

    expect_t     pending[$];
    int          cycle;
    logic [31:0] rng_state;

    ntt_butterfly_2x2 ntt_butterfly_2x2_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .enable_i     (enable),
        .accumulate_i (accumulate),
        .mode_i       (mode),
        .uvw_i        (uvw),
        .pw_uvw_i     (pw_uvw),
        .uv_o         (uv),
        .pw_uv_o      (pw_uv),
        .ready_o      (ready)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic coeff_t random_coeff();
        return coeff_t'(next_random() % 32'(`NTT_Q));
    endfunction

    // First groups of a pointwise run use 0 and q-1 in every combination
    function automatic coeff_t pw_operand(int n, int k);
        case (n)
            0:       return `NTT_Q - 1;
            1:       return '0;
            2:       return k[2] ? `NTT_Q - 1 : '0;
            3:       return k[2] ? '0 : `NTT_Q - 1;
            default: return random_coeff();
        endcase
    endfunction

    // Outputs must be zero unless a group is due in this very cycle
    task automatic observe_outputs();
        expect_t e;
        if (ready) begin
            if (pending.size() == 0) begin
                fail_run("ready_o pulsed with no group in flight");
            end else begin
                e = pending.pop_front();
                check_value("ready_o cycle", cycle, e.due);
                if (e.pw) begin
                    check_value("pw_uv_o.uv0", pw_uv.uv0, e.pw_uv.uv0);
                    check_value("pw_uv_o.uv1", pw_uv.uv1, e.pw_uv.uv1);
                    check_value("pw_uv_o.uv2", pw_uv.uv2, e.pw_uv.uv2);
                    check_value("pw_uv_o.uv3", pw_uv.uv3, e.pw_uv.uv3);
                    check_value("uv_o", uv, '0);
                end else begin
                    check_value("uv_o.u20", uv.u20, e.uv.u20);
                    check_value("uv_o.v20", uv.v20, e.uv.v20);
                    check_value("uv_o.u21", uv.u21, e.uv.u21);
                    check_value("uv_o.v21", uv.v21, e.uv.v21);
                    check_value("pw_uv_o", pw_uv, '0);
                end
            end
        end else begin
            check_value("uv_o", uv, '0);
            check_value("pw_uv_o", pw_uv, '0);
            if (pending.size() != 0 && pending[0].due <= cycle) begin
                fail_run($sformatf("ready_o missing at %0t ns for a group that was due", $time));
            end
        end
    endtask

    // Outputs are read at the falling edge, before new inputs are driven
    task automatic wait_cycle();
        @(negedge clk);
        cycle++;
        observe_outputs();
        enable  = 1'b0;
        zeroize = 1'b0;
    endtask

    task automatic issue_bf_group(input bf_uvw_t g);
        expect_t e;
        e       = '0;
        e.due   = cycle + LAT2;
        e.uv    = (mode == ct) ? ct_group(g) : gs_group(g);
        uvw     = g;
        enable  = 1'b1;
        pending.push_back(e);
    endtask

    task automatic issue_pw_group(input pw_uvw_t g);
        expect_t e;
        e       = '0;
        e.pw    = 1'b1;
        e.due   = cycle + LAT1;
        e.pw_uv = pw_group(mode, accumulate, g);
        pw_uvw  = g;
        enable  = 1'b1;
        pending.push_back(e);
    endtask

    function automatic bf_uvw_t random_bf_group();
        bf_uvw_t g;
        for (int k = 0; k < 8; k++) begin
            g[k*`NTT_WIDTH +: `NTT_WIDTH] = random_coeff();
        end
        return g;
    endfunction

    task automatic drain_pipeline();
        while (pending.size() != 0) begin
            wait_cycle();
        end
        repeat (2) wait_cycle();
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic check_quiet_after_reset();
        repeat (10) begin
            wait_cycle();
            uvw = random_bf_group();
            pw_uvw = pw_uvw_t'({uvw, uvw[91:0]});
        end
    endtask

    task automatic run_ct_back_to_back();
        mode = ct;
        repeat (20) begin
            wait_cycle();
            issue_bf_group(random_bf_group());
        end
        drain_pipeline();
    endtask

    task automatic run_gs_with_gaps();
        mode = gs;
        repeat (20) begin
            repeat (1 + next_random() % 3) wait_cycle();
            wait_cycle();
            issue_bf_group(random_bf_group());
        end
        drain_pipeline();
    endtask

    task automatic run_pointwise(input mode_t m, input logic acc);
        pw_uvw_t g;
        mode = m;
        accumulate = acc;
        for (int n = 0; n < 10; n++) begin
            for (int k = 0; k < 12; k++) begin
                g[k*`NTT_WIDTH +: `NTT_WIDTH] = pw_operand(n, k);
            end
            wait_cycle();
            issue_pw_group(g);
        end
        drain_pipeline();
        accumulate = 1'b0;
    endtask

    // Groups cut off by zeroize must never show up
    task automatic run_zeroize();
        mode = ct;
        repeat (ZERO_GROUPS) begin
            wait_cycle();
            issue_bf_group(random_bf_group());
        end
        wait_cycle();
        zeroize = 1'b1;
        pending.delete();
        repeat (LAT2 + 4) wait_cycle();
        wait_cycle();
        issue_bf_group(random_bf_group());
        drain_pipeline();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        accumulate = 1'b0;
        mode       = ct;
        uvw        = '0;
        pw_uvw     = '0;
        cycle      = 0;
        rng_state  = 32'heec3;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        check_quiet_after_reset();
        run_ct_back_to_back();
        run_gs_with_gaps();
        run_pointwise(pwm, 1'b0);
        run_pointwise(pwm, 1'b1);
        run_pointwise(pwa, 1'b0);
        run_pointwise(pws, 1'b0);
        run_zeroize();

        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("timeout: the run went on far longer than the tests need");
    end

endmodule

`default_nettype wire

// File: ntt_butterfly_2x2.f
+incdir+hdl
+incdir+dv
hdl/ntt_pkg.sv
hdl/ntt_mod_mult.sv
hdl/ntt_butterfly.sv
hdl/ntt_butterfly_2x2.sv
dv/tb_ntt_butterfly_2x2.sv

// File: run.sh
#!/usr/bin/env bash
# Build the 2x2 NTT butterfly testbench with Verilator and run it.
# The result is read from the simulation log.
set -e

cd "$(dirname "$0")"

TOP=tb_ntt_butterfly_2x2
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -f ntt_butterfly_2x2.f

# The log decides the result, so the exit code of the run is not used here
./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation PASSED"
